// ==== test/mmt_vectors.txt ====
# m: one matrix row of four signed elements, matrices 0 to 3 in order
# q: mode idx_a idx_b idx_c expected_sum (decimal)
m 1 2 0 -1
m 0 1 3 0
m -2 0 1 1
m 1 0 0 2
m 2 0 1 0
m 1 -1 0 2
m 0 3 1 0
m 0 0 -2 1
m 1 0 0 2
m 0 1 -1 0
m 3 0 1 0
m 0 -2 0 1
m 127 0 0 -128
m 0 1 0 0
m 0 0 -1 0
m 100 0 0 2
q 0 0 1 2 17
q 1 0 1 2 -13
q 2 0 1 2 38
q 3 0 1 2 2
q 0 3 3 1 -6138
q 3 3 3 3 3800727
q 1 2 0 3 -816
q 2 1 2 0 2

// ==== all.f ====
source/mmt_pkg.sv
source/matrix_loader.sv
source/matrix_store.sv
source/triple_product_unit.sv
source/mmt_top.sv
test/mmt_checker.sv
test/mmt_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS = --binary --timing --assert --timescale 1ns/100ps -j 0
TOP = mmt_tb
FILELIST = all.f
OBJ_DIR = obj_dir
LOG = sim.log

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q "TEST PASSED" $(LOG); then echo "Simulation ended without a verdict"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== test/mmt_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module mmt_tb
	import mmt_pkg::*;
();

	localparam int side = 4;
	localparam int num_matrices = 4;

	logic clk;
	logic rst_n;
	logic in_valid;
	logic in_valid2;
	elem_t matrix;
	mat_idx_t matrix_idx;
	mode_t mode;
	logic out_valid;
	acc_t out_value;

	// Stimulus and expected sums from the vector file
	elem_t load_data[$];
	query_t q_list[$];
	longint exp_list[$];

	int error_count = 0;
	int check_count = 0;
	int cycle_count = 0;
	int timeout_limit = 0;

	mmt_top #(
		.side(side),
		.num_matrices(num_matrices)
	) UUT (
		.clk(clk),
		.rst_n(rst_n),
		.in_valid(in_valid),
		.in_valid2(in_valid2),
		.matrix(matrix),
		.matrix_idx(matrix_idx),
		.mode(mode),
		.out_valid(out_valid),
		.out_value(out_value)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Run limit set once the vector file is read
	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (timeout_limit > 0 && cycle_count >= timeout_limit) begin
			$display("Timeout: no result arrived within %0d cycles", timeout_limit);
			$display("TEST FAILED");
			$finish;
		end
	end

	// ----------------------------------------------------------------------
	// Helpers
	// ----------------------------------------------------------------------

	task automatic check_value(input string name, input logic [63:0] got,
		input logic [63:0] expected);
		check_count++;
		if (got !== expected) begin
			error_count++;
			$display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, expected);
		end
	endtask

	task automatic check_idle();
		check_value("out_valid", 64'(out_valid), 64'd0);
		check_value("out_value", 64'(out_value), 64'd0);
	endtask

	task automatic read_vectors();
		int fd;
		int n;
		int f0;
		int f1;
		int f2;
		int f3;
		longint f4;
		byte tag;
		string line;
		query_t qv;

		fd = $fopen("test/mmt_vectors.txt", "r");
		if (fd == 0) begin
			$display("Cannot open test/mmt_vectors.txt, no stimulus was loaded");
			error_count++;
			return;
		end
		while ($fgets(line, fd) != 0) begin
			tag = line.getc(0);
			if (tag == "m") begin
				n = $sscanf(line.substr(1, line.len() - 1), "%d %d %d %d",
					f0, f1, f2, f3);
				if (n == 4) begin
					load_data.push_back(elem_t'(f0));
					load_data.push_back(elem_t'(f1));
					load_data.push_back(elem_t'(f2));
					load_data.push_back(elem_t'(f3));
				end else begin
					$display("Malformed matrix row in vector file: %s", line);
					error_count++;
				end
			end else if (tag == "q") begin
				n = $sscanf(line.substr(1, line.len() - 1), "%d %d %d %d %d",
					f0, f1, f2, f3, f4);
				if (n == 5) begin
					qv.mode = mode_t'(f0);
					qv.idx_a = mat_idx_t'(f1);
					qv.idx_b = mat_idx_t'(f2);
					qv.idx_c = mat_idx_t'(f3);
					q_list.push_back(qv);
					exp_list.push_back(f4);
				end else begin
					$display("Malformed query line in vector file: %s", line);
					error_count++;
				end
			end
		end
		$fclose(fd);
	endtask

	// One element per cycle in row-major order
	task automatic load_matrices();
		foreach (load_data[e]) begin
			@(posedge clk);
			in_valid <= 1'b1;
			matrix <= load_data[e];
			@(negedge clk);
			check_idle();
		end
		@(posedge clk);
		in_valid <= 1'b0;
		matrix <= '0;
	endtask

	// Three query cycles with the mode valid on the first only
	task automatic send_query(input query_t q);
		@(posedge clk);
		in_valid2 <= 1'b1;
		mode <= q.mode;
		matrix_idx <= q.idx_a;
		@(posedge clk);
		// Loader must ignore the mode input from here on
		mode <= ~q.mode;
		matrix_idx <= q.idx_b;
		@(posedge clk);
		matrix_idx <= q.idx_c;
		@(posedge clk);
		in_valid2 <= 1'b0;
		matrix_idx <= '0;
		mode <= '0;
	endtask

	task automatic wait_result(output acc_t value);
		@(negedge clk);
		while (!out_valid) begin
			@(negedge clk);
		end
		value = out_value;
		// Pulse must be gone one cycle later
		@(negedge clk);
		check_value("out_valid", 64'(out_valid), 64'd0);
	endtask

	// ----------------------------------------------------------------------
	// Main sequence
	// ----------------------------------------------------------------------

	initial begin
		query_t q;
		query_t base_q;
		acc_t got;
		acc_t base_sum;
		logic have_base;
		int unsigned gap;
		int total_errors;

		void'($urandom(46));
		rst_n = 1'b0;
		in_valid = 1'b0;
		in_valid2 = 1'b0;
		matrix = '0;
		matrix_idx = '0;
		mode = '0;
		have_base = 1'b0;
		base_sum = '0;
		base_q = '0;

		read_vectors();
		check_value("matrix elements in vector file", 64'(load_data.size()),
			64'(num_matrices * side * side));
		timeout_limit = q_list.size() * 200 + load_data.size() + 100;

		repeat (3) @(posedge clk);
		rst_n <= 1'b1;

		// Quiet output after reset
		repeat (2) begin
			@(negedge clk);
			check_idle();
		end
		load_matrices();
		repeat (4) begin
			@(negedge clk);
			check_idle();
		end

		for (int n = 0; n < q_list.size(); n++) begin
			q = q_list[n];
			send_query(q);
			wait_result(got);
			check_value("out_value", 64'(got), exp_list[n]);
			if (q.mode == 2'd0) begin
				base_sum = got;
				base_q = q;
				have_base = 1'b1;
			end else if (have_base && (q.mode == mode_atb || q.mode == mode_abt)
				&& q.idx_a == base_q.idx_a && q.idx_b == base_q.idx_b
				&& q.idx_c == base_q.idx_c) begin
				check_value("out_value differs from mode 0", 64'(got != base_sum), 64'd1);
			end
			gap = $urandom % 6;
			repeat (gap) begin
				@(negedge clk);
				check_idle();
			end
		end

		total_errors = error_count + int'(UUT.u_checker.fail_count);
		$display("Checks: %0d, errors: %0d, assertion failures: %0d",
			check_count, error_count, UUT.u_checker.fail_count);
		if (total_errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== test/mmt_checker.sv ====
`timescale 1ns/100ps
`default_nettype none

module mmt_checker
	import mmt_pkg::*;
(
	input wire logic clk,
	input wire logic rst_n,
	input wire logic in_valid2,
	input wire logic busy,
	input wire logic out_valid,
	input wire acc_t out_value
);

	int unsigned pulse_fails = 0;
	int unsigned idle_fails = 0;
	int unsigned overlap_fails = 0;
	int unsigned fail_count;

	assign fail_count = pulse_fails + idle_fails + overlap_fails;

	// Result is a single-cycle pulse
	single_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid |=> !out_valid)
	else begin
		pulse_fails = pulse_fails + 1;
		$error("out_valid stayed high for two cycles");
	end

	// Output bus quiet between results
	quiet_value: assert property (@(posedge clk) disable iff (!rst_n)
		!out_valid |-> (out_value == '0))
	else begin
		idle_fails = idle_fails + 1;
		$error("out_value not zero while out_valid is low");
	end

	// No new query while the unit works
	no_overlap: assert property (@(posedge clk) disable iff (!rst_n)
		busy |-> !in_valid2)
	else begin
		overlap_fails = overlap_fails + 1;
		$error("in_valid2 high while the unit is busy");
	end

endmodule

bind mmt_top mmt_checker u_checker (
	.clk(clk),
	.rst_n(rst_n),
	.in_valid2(in_valid2),
	.busy(busy),
	.out_valid(out_valid),
	.out_value(out_value)
);

`default_nettype wire

// ==== source/mmt_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module mmt_top
	import mmt_pkg::*;
#(
	parameter int side = 4,
	parameter int num_matrices = 4
) (
	input  wire logic clk,
	input  wire logic rst_n,
	input  wire logic in_valid,
	input  wire logic in_valid2,
	input  wire elem_t matrix,
	input  wire mat_idx_t matrix_idx,
	input  wire mode_t mode,
	output logic out_valid,
	output acc_t out_value
);

	localparam int addr_w = $clog2(num_matrices * side * side);

	// Loader to store
	logic wr_en;
	logic [addr_w-1:0] wr_addr;
	elem_t wr_data;

	// Loader and unit handshake
	query_t query;
	logic start;
	logic busy;

	// Unit read port
	logic [addr_w-1:0] rd_addr;
	elem_t rd_data;

	matrix_loader #(
		.side(side),
		.num_matrices(num_matrices)
	) u_loader (
		.clk(clk),
		.rst_n(rst_n),
		.in_valid(in_valid),
		.in_valid2(in_valid2),
		.matrix(matrix),
		.matrix_idx(matrix_idx),
		.mode(mode),
		.busy(busy),
		.wr_en(wr_en),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.query(query),
		.start(start)
	);

	matrix_store #(
		.side(side),
		.num_matrices(num_matrices)
	) u_store (
		.clk(clk),
		.rst_n(rst_n),
		.wr_en(wr_en),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.rd_addr(rd_addr),
		.rd_data(rd_data)
	);

	triple_product_unit #(
		.side(side),
		.num_matrices(num_matrices)
	) u_unit (
		.clk(clk),
		.rst_n(rst_n),
		.query(query),
		.start(start),
		.rd_addr(rd_addr),
		.rd_data(rd_data),
		.busy(busy),
		.out_valid(out_valid),
		.out_value(out_value)
	);

endmodule

`default_nettype wire

// ==== source/triple_product_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module triple_product_unit
	import mmt_pkg::*;
#(
	parameter int side = 4,
	parameter int num_matrices = 4
) (
	input  wire logic clk,
	input  wire logic rst_n,
	input  wire query_t query,
	input  wire logic start,
	output logic [$clog2(num_matrices * side * side)-1:0] rd_addr,
	input  wire elem_t rd_data,
	output logic busy,
	output logic out_valid,
	output acc_t out_value
);

	localparam int area = side * side;
	localparam int addr_w = $clog2(num_matrices * area);
	localparam int cnt_w = (side > 1) ? $clog2(side) : 1;

	engine_state_t state;
	engine_state_t state_next;

	query_t q_reg;

	logic [cnt_w-1:0] row_i;
	logic [cnt_w-1:0] col_j;
	logic [cnt_w-1:0] k_idx;
	logic last_k;
	logic last_pos;

	logic [addr_w-1:0] base_a;
	logic [addr_w-1:0] base_b;
	logic [addr_w-1:0] base_c;
	logic [addr_w-1:0] a_addr;
	logic [addr_w-1:0] b_addr;
	logic [addr_w-1:0] c_addr;

	// A term held while the matching B element is read
	elem_t a_reg;
	acc_t partial;
	acc_t acc;

	function automatic logic [addr_w-1:0] mat_base(input mat_idx_t idx);
		mat_base = addr_w'(idx * area);
	endfunction

	function automatic logic [addr_w-1:0] elem_addr(
		input logic [addr_w-1:0] base,
		input logic [cnt_w-1:0] r,
		input logic [cnt_w-1:0] c
	);
		elem_addr = base + addr_w'(r) * addr_w'(side) + addr_w'(c);
	endfunction

	// ----------------------------------------------------------------------
	// Address generation
	// ----------------------------------------------------------------------

	assign base_a = mat_base(q_reg.idx_a);
	assign base_b = mat_base(q_reg.idx_b);
	assign base_c = mat_base(q_reg.idx_c);

	assign a_addr = (q_reg.mode == mode_atb) ? elem_addr(base_a, k_idx, row_i)
		: elem_addr(base_a, row_i, k_idx);
	assign b_addr = (q_reg.mode == mode_abt) ? elem_addr(base_b, col_j, k_idx)
		: elem_addr(base_b, k_idx, col_j);
	// C is read transposed except in mode 3
	assign c_addr = (q_reg.mode == mode_ab_c) ? elem_addr(base_c, row_i, col_j)
		: elem_addr(base_c, col_j, row_i);

	// k already points at the next term while in mac
	always_comb begin
		unique case (state)
			st_read_b: rd_addr = b_addr;
			st_read_c: rd_addr = c_addr;
			default:   rd_addr = a_addr;
		endcase
	end

	assign last_k = (k_idx == cnt_w'(side - 1));
	assign last_pos = (row_i == cnt_w'(side - 1)) && (col_j == cnt_w'(side - 1));
	assign busy = (state != st_idle);

	// ----------------------------------------------------------------------
	// Engine FSM
	// ----------------------------------------------------------------------

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= st_idle;
		end else begin
			state <= state_next;
		end
	end

	always_comb begin
		state_next = state;
		case (state)
			st_idle:   if (start) state_next = st_read_a;
			st_read_a: state_next = st_read_b;
			st_read_b: state_next = last_k ? st_read_c : st_mac;
			st_mac:    state_next = st_read_b;
			st_read_c: state_next = st_scale;
			st_scale:  state_next = last_pos ? st_done : st_read_a;
			st_done:   state_next = st_idle;
			default:   state_next = st_idle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (state == st_idle && start) begin
			q_reg <= query;
		end
		if (state == st_read_b) begin
			a_reg <= rd_data;
		end
	end

	// ----------------------------------------------------------------------
	// Counters and accumulation
	// ----------------------------------------------------------------------

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			row_i <= '0;
			col_j <= '0;
			k_idx <= '0;
			partial <= '0;
			acc <= '0;
			out_valid <= 1'b0;
			out_value <= '0;
		end else begin
			out_valid <= (state == st_done);
			out_value <= (state == st_done) ? acc : '0;
			case (state)
				st_read_b: begin
					k_idx <= last_k ? '0 : k_idx + 1'b1;
				end
				// Read C overlaps the last k product
				st_mac, st_read_c: begin
					partial <= partial + a_reg * rd_data;
				end
				st_scale: begin
					acc <= acc + partial * rd_data;
					partial <= '0;
					if (col_j == cnt_w'(side - 1)) begin
						col_j <= '0;
						row_i <= (row_i == cnt_w'(side - 1)) ? '0 : row_i + 1'b1;
					end else begin
						col_j <= col_j + 1'b1;
					end
				end
				st_done: begin
					acc <= '0;
				end
				default: begin
					partial <= partial;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== source/matrix_store.sv ====
`timescale 1ns/100ps
`default_nettype none

module matrix_store
	import mmt_pkg::*;
#(
	parameter int side = 4,
	parameter int num_matrices = 4
) (
	input  wire logic clk,
	input  wire logic rst_n,
	input  wire logic wr_en,
	input  wire logic [$clog2(num_matrices * side * side)-1:0] wr_addr,
	input  wire elem_t wr_data,
	input  wire logic [$clog2(num_matrices * side * side)-1:0] rd_addr,
	output elem_t rd_data
);

	localparam int depth = num_matrices * side * side;

	// Matrices stored back to back, each in row-major order
	elem_t mem [0:depth-1];

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
	end

	// Registered read port, data valid one cycle after the address
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rd_data <= '0;
		end else begin
			rd_data <= mem[rd_addr];
		end
	end

endmodule

`default_nettype wire

// ==== source/matrix_loader.sv ====
`timescale 1ns/100ps
`default_nettype none

module matrix_loader
	import mmt_pkg::*;
#(
	parameter int side = 4,
	parameter int num_matrices = 4
) (
	input  wire logic clk,
	input  wire logic rst_n,
	input  wire logic in_valid,
	input  wire logic in_valid2,
	input  wire elem_t matrix,
	input  wire mat_idx_t matrix_idx,
	input  wire mode_t mode,
	input  wire logic busy,
	output logic wr_en,
	output logic [$clog2(num_matrices * side * side)-1:0] wr_addr,
	output elem_t wr_data,
	output query_t query,
	output logic start
);

	localparam int addr_w = $clog2(num_matrices * side * side);

	// Position of the next element inside the load burst
	logic [addr_w-1:0] load_cnt;

	// Which of the three query cycles comes next
	logic [1:0] q_cnt;

	// ----------------------------------------------------------------------
	// Load burst
	// ----------------------------------------------------------------------

	// Counter restarts as soon as in_valid drops
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			load_cnt <= '0;
			wr_en <= 1'b0;
		end else begin
			wr_en <= in_valid;
			if (in_valid) begin
				load_cnt <= load_cnt + 1'b1;
			end else begin
				load_cnt <= '0;
			end
		end
	end

	// Element goes to the store one cycle after it arrives
	always_ff @(posedge clk) begin
		wr_addr <= load_cnt;
		wr_data <= matrix;
	end

	// ----------------------------------------------------------------------
	// Query capture
	// ----------------------------------------------------------------------

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			q_cnt <= 2'd0;
			start <= 1'b0;
		end else begin
			// Start follows the third cycle, dropped while the unit works
			start <= in_valid2 && (q_cnt == 2'd2) && !busy;
			if (in_valid2) begin
				q_cnt <= q_cnt + 2'd1;
			end else begin
				q_cnt <= 2'd0;
			end
		end
	end

	// Mode only on the first cycle, then A, B and C in turn
	always_ff @(posedge clk) begin
		if (in_valid2) begin
			case (q_cnt)
				2'd0: begin
					query.mode <= mode;
					query.idx_a <= matrix_idx;
				end
				2'd1: begin
					query.idx_b <= matrix_idx;
				end
				2'd2: begin
					query.idx_c <= matrix_idx;
				end
				default: begin
					query <= query;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== source/mmt_pkg.sv ====
`default_nettype none

package mmt_pkg;

	// ----------------------------------------------------------------------
	// Data widths
	// ----------------------------------------------------------------------

	// One matrix element as loaded on the matrix input
	typedef logic signed [7:0] elem_t;

	// Number of a matrix in the bank
	typedef logic [4:0] mat_idx_t;

	// Transpose mode of a query
	typedef logic [1:0] mode_t;

	// Final sum and running accumulator
	typedef logic signed [49:0] acc_t;

	// Mode 0 is the plain A*B product with C read at (j,i)
	localparam mode_t mode_atb = 2'd1;
	localparam mode_t mode_abt = 2'd2;
	localparam mode_t mode_ab_c = 2'd3;

	// ----------------------------------------------------------------------
	// Query and engine control
	// ----------------------------------------------------------------------

	// Complete query, handed from loader to arithmetic unit
	typedef struct packed {
		mode_t    mode;
		mat_idx_t idx_a;
		mat_idx_t idx_b;
		mat_idx_t idx_c;
	} query_t;

	typedef enum logic [2:0] {
		st_idle,
		st_read_a,
		st_read_b,
		st_mac,
		st_read_c,
		st_scale,
		st_done
	} engine_state_t;

endpackage

`default_nettype wire
